// File: tb.f
rtl/ooo_pkg.sv
rtl/rename_regfile.sv
rtl/reservation_station.sv
rtl/alu_unit.sv
rtl/reorder_buffer.sv
rtl/ooo_core.sv
tests/ooo_core_assertions.sv
tests/tb_ooo_core.sv

// File: Bender.yml
package:
  name: ooo_core

sources:
  - rtl/ooo_pkg.sv
  - rtl/rename_regfile.sv
  - rtl/reservation_station.sv
  - rtl/alu_unit.sv
  - rtl/reorder_buffer.sv
  - rtl/ooo_core.sv
  - target: test
    files:
      - tests/ooo_core_assertions.sv
      - tests/tb_ooo_core.sv

// File: tests/tb_ooo_core.sv
`timescale 1ns/10ps

module tb_ooo_core import ooo_pkg::*; ();

    localparam int unsigned SEED      = 32'hbd2e_b078;
    localparam int          NUM_INSTR = 2000;
    localparam int          WATCHDOG_CYCLES = NUM_INSTR * 20 + 200;

    logic             clk;
    logic             rst;
    logic             in_valid;
    alu_op_e          in_op;
    reg_idx_t         in_rd;
    reg_idx_t         in_rs1;
    reg_idx_t         in_rs2;
    logic [IMM_W-1:0] in_imm;
    logic             commit_valid;
    reg_idx_t         commit_rd;
    data_t            commit_data;

    // Reference model state and expected commit stream
    data_t       model_regs [REG_COUNT];
    reg_idx_t    exp_rd_q   [$];
    data_t       exp_data_q [$];
    int          errors;
    int          credits;
    int          sent;
    int          commits;
    int          stall_cycles;
    int          chain_left;
    int          cycle;
    int          send_rate;
    reg_idx_t    last_rd;

    ooo_core dut0 (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_op        (in_op),
        .in_rd        (in_rd),
        .in_rs1       (in_rs1),
        .in_rs2       (in_rs2),
        .in_imm       (in_imm),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic data_t compute_result(alu_op_e op, data_t a, data_t b,
                                             logic [IMM_W-1:0] imm);
        data_t imm_ext;
        imm_ext = {{(DATA_W-IMM_W){imm[IMM_W-1]}}, imm};
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLT:  return ($signed(a) < $signed(b)) ? data_t'(1) : data_t'(0);
            OP_ADDI: return a + imm_ext;
            default: return '0;
        endcase
    endfunction

    // Mostly registers 0..3 so that dependencies show up often
    function automatic reg_idx_t pick_reg();
        if ($urandom_range(0, 3) != 0) begin
            return reg_idx_t'($urandom_range(0, 3));
        end
        return reg_idx_t'($urandom_range(0, REG_COUNT - 1));
    endfunction

    task automatic check_idle(input string phase);
        if (commit_valid !== 1'b0) begin
            $display("ERROR reset_idle (%s): expected 0, actual %b", phase, commit_valid);
            errors++;
        end
    endtask

    task automatic collect_commit();
        reg_idx_t exp_rd;
        data_t    exp_data;
        if (commit_valid !== 1'b1) begin
            return;
        end
        credits++;
        commits++;
        if (exp_rd_q.size() == 0) begin
            $display("Unexpected commit of rd %0d with no instruction outstanding", commit_rd);
            errors++;
            return;
        end
        exp_rd   = exp_rd_q.pop_front();
        exp_data = exp_data_q.pop_front();
        if (commit_rd !== exp_rd) begin
            $display("ERROR %s: expected rd %0d, actual rd %0d",
                     (exp_rd == '0) ? "reg_zero" : "commit_order", exp_rd, commit_rd);
            errors++;
        end
        if (commit_data !== exp_data) begin
            $display("ERROR alu_results: expected %h, actual %h", exp_data, commit_data);
            errors++;
        end
    endtask

    task automatic send_instr();
        alu_op_e          op;
        reg_idx_t         rd;
        reg_idx_t         rs1;
        reg_idx_t         rs2;
        logic [IMM_W-1:0] imm;
        data_t            result;
        op  = alu_op_e'($urandom_range(0, 6));
        rd  = pick_reg();
        rs1 = pick_reg();
        rs2 = pick_reg();
        imm = IMM_W'($urandom_range(0, 16'hffff));
        // Chains read the previous result, sometimes on both sources
        if (chain_left > 0) begin
            rs1 = last_rd;
            if ($urandom_range(0, 2) == 0) begin
                rs2 = last_rd;
            end
            rd = reg_idx_t'($urandom_range(1, REG_COUNT - 1));
            chain_left--;
        end else if ($urandom_range(0, 11) == 0) begin
            chain_left = $urandom_range(2, 8);
        end
        in_valid = 1'b1;
        in_op    = op;
        in_rd    = rd;
        in_rs1   = rs1;
        in_rs2   = rs2;
        in_imm   = imm;
        result   = compute_result(op, model_regs[rs1], model_regs[rs2], imm);
        exp_rd_q.push_back(rd);
        exp_data_q.push_back(result);
        if (rd != '0) begin
            model_regs[rd] = result;
        end
        last_rd = rd;
    endtask

    initial begin
        void'($urandom(SEED));
        errors       = 0;
        credits      = ROB_DEPTH;
        sent         = 0;
        commits      = 0;
        stall_cycles = 0;
        chain_left   = 0;
        cycle        = 0;
        last_rd      = '0;
        for (int i = 0; i < REG_COUNT; i++) begin
            model_regs[i] = '0;
        end
        rst      = 1'b1;
        in_valid = 1'b0;
        in_op    = OP_ADD;
        in_rd    = '0;
        in_rs1   = '0;
        in_rs2   = '0;
        in_imm   = '0;

        repeat (5) begin
            @(negedge clk);
            check_idle("in reset");
        end
        rst = 1'b0;
        repeat (4) begin
            @(negedge clk);
            check_idle("after reset");
        end

        // Alternate full-rate and sparse phases
        while (commits < NUM_INSTR) begin
            @(negedge clk);
            in_valid = 1'b0;
            collect_commit();
            send_rate = ((cycle / 64) % 2 == 0) ? 100 : 35;
            if (sent < NUM_INSTR) begin
                if (credits == 0) begin
                    stall_cycles++;
                end else if ($urandom_range(1, 100) <= send_rate) begin
                    send_instr();
                    credits--;
                    sent++;
                end
            end
            cycle++;
        end

        // Any further commit now finds the queue empty
        repeat (12) begin
            @(negedge clk);
            collect_commit();
        end

        if (commits != NUM_INSTR) begin
            $display("ERROR credit_drain: expected %0d commits, actual %0d", NUM_INSTR, commits);
            errors++;
        end
        if (credits != ROB_DEPTH) begin
            $display("ERROR credit_drain: expected %0d credits, actual %0d", ROB_DEPTH, credits);
            errors++;
        end
        if (stall_cycles == 0) begin
            $display("Credits never ran out, so dispatch never stalled");
            errors++;
        end
        if (dut0.rob0.rob_checks.failures != 0) begin
            $display("ROB assertions failed %0d times", dut0.rob0.rob_checks.failures);
            errors += dut0.rob0.rob_checks.failures;
        end

        $display("Checks done: %0d errors, %0d commits, %0d stall cycles",
                 errors, commits, stall_cycles);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: commits stopped arriving after %0d of %0d instructions",
                 commits, NUM_INSTR);
        $display("Checks done: %0d errors, %0d commits, %0d stall cycles",
                 errors, commits, stall_cycles);
        $display("Test FAILED");
        $finish;
    end

endmodule

// File: tests/ooo_core_assertions.sv
`timescale 1ns/10ps

module ooo_core_assertions import ooo_pkg::*; (
    input logic                 clk,
    input logic                 rst,
    input rob_tag_t             head,
    input logic [ROB_CNT_W-1:0] count,
    input logic                 done_q [ROB_DEPTH],
    input logic                 cdb_valid,
    input rob_tag_t             cdb_tag,
    input logic                 commit_valid
);

    rob_tag_t cdb_offset;
    logic     cdb_busy;
    logic     cdb_done;
    int       failures = 0;

    // Busy entries run from head for count slots
    assign cdb_offset = cdb_tag - head;
    assign cdb_busy   = ROB_CNT_W'(cdb_offset) < count;
    assign cdb_done   = done_q[cdb_tag];

    count_in_range: assert property (@(posedge clk) disable iff (rst)
        count <= ROB_CNT_W'(ROB_DEPTH))
        else begin
            $error("ROB entry count exceeds ROB_DEPTH");
            failures++;
        end

    cdb_names_live_entry: assert property (@(posedge clk) disable iff (rst)
        cdb_valid |-> (cdb_busy && !cdb_done))
        else begin
            $error("CDB result for an entry that is free or already done");
            failures++;
        end

    commit_known: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(commit_valid))
        else begin
            $error("commit_valid is unknown");
            failures++;
        end

endmodule

bind reorder_buffer ooo_core_assertions rob_checks (
    .clk          (clk),
    .rst          (rst),
    .head         (head),
    .count        (count),
    .done_q       (done_q),
    .cdb_valid    (cdb_valid),
    .cdb_tag      (cdb_tag),
    .commit_valid (commit_valid)
);

// File: rtl/ooo_core.sv
`timescale 1ns/10ps

module ooo_core import ooo_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid,
    input  alu_op_e          in_op,
    input  reg_idx_t         in_rd,
    input  reg_idx_t         in_rs1,
    input  reg_idx_t         in_rs2,
    input  logic [IMM_W-1:0] in_imm,
    output logic             commit_valid,
    output reg_idx_t         commit_rd,
    output data_t            commit_data
);

    rob_tag_t alloc_tag;
    rob_tag_t commit_tag;
    data_t    src1_value;
    data_t    src2_value;
    logic     src1_pending;
    logic     src2_pending;
    rob_tag_t src1_tag;
    rob_tag_t src2_tag;
    logic     rob_done1;
    logic     rob_done2;
    data_t    rob_value1;
    data_t    rob_value2;
    logic     issue_valid;
    alu_op_e  issue_op;
    data_t    issue_a;
    data_t    issue_b;
    rob_tag_t issue_tag;
    logic     cdb_valid;
    rob_tag_t cdb_tag;
    data_t    cdb_data;

    rename_regfile rename0 (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_rd        (in_rd),
        .in_rs1       (in_rs1),
        .in_rs2       (in_rs2),
        .alloc_tag    (alloc_tag),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data),
        .commit_tag   (commit_tag),
        .src1_value   (src1_value),
        .src2_value   (src2_value),
        .src1_pending (src1_pending),
        .src2_pending (src2_pending),
        .src1_tag     (src1_tag),
        .src2_tag     (src2_tag)
    );

    reservation_station rs0 (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_op        (in_op),
        .in_imm       (in_imm),
        .alloc_tag    (alloc_tag),
        .src1_value   (src1_value),
        .src2_value   (src2_value),
        .src1_pending (src1_pending),
        .src2_pending (src2_pending),
        .src1_tag     (src1_tag),
        .src2_tag     (src2_tag),
        .rob_done1    (rob_done1),
        .rob_done2    (rob_done2),
        .rob_value1   (rob_value1),
        .rob_value2   (rob_value2),
        .cdb_valid    (cdb_valid),
        .cdb_tag      (cdb_tag),
        .cdb_data     (cdb_data),
        .issue_valid  (issue_valid),
        .issue_op     (issue_op),
        .issue_a      (issue_a),
        .issue_b      (issue_b),
        .issue_tag    (issue_tag)
    );

    alu_unit alu0 (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .issue_a     (issue_a),
        .issue_b     (issue_b),
        .issue_tag   (issue_tag),
        .cdb_valid   (cdb_valid),
        .cdb_tag     (cdb_tag),
        .cdb_data    (cdb_data)
    );

    reorder_buffer rob0 (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_rd        (in_rd),
        .src1_tag     (src1_tag),
        .src2_tag     (src2_tag),
        .cdb_valid    (cdb_valid),
        .cdb_tag      (cdb_tag),
        .cdb_data     (cdb_data),
        .alloc_tag    (alloc_tag),
        .rob_done1    (rob_done1),
        .rob_done2    (rob_done2),
        .rob_value1   (rob_value1),
        .rob_value2   (rob_value2),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data),
        .commit_tag   (commit_tag)
    );

endmodule

// File: rtl/reorder_buffer.sv
`timescale 1ns/10ps

module reorder_buffer import ooo_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  reg_idx_t in_rd,
    input  rob_tag_t src1_tag,
    input  rob_tag_t src2_tag,
    input  logic     cdb_valid,
    input  rob_tag_t cdb_tag,
    input  data_t    cdb_data,
    output rob_tag_t alloc_tag,
    output logic     rob_done1,
    output logic     rob_done2,
    output data_t    rob_value1,
    output data_t    rob_value2,
    output logic     commit_valid,
    output reg_idx_t commit_rd,
    output data_t    commit_data,
    output rob_tag_t commit_tag
);

    rob_tag_t             head;
    rob_tag_t             tail;
    logic [ROB_CNT_W-1:0] count;
    logic                 done_q  [ROB_DEPTH];
    reg_idx_t             rd_q    [ROB_DEPTH];
    data_t                value_q [ROB_DEPTH];
    logic                 fire;

    assign alloc_tag = tail;

    // Head retires once its result is in
    assign fire = (count != '0) && done_q[head];

    // Operand lookups for the dispatching instruction
    assign rob_done1  = done_q[src1_tag];
    assign rob_done2  = done_q[src2_tag];
    assign rob_value1 = value_q[src1_tag];
    assign rob_value2 = value_q[src2_tag];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            commit_valid <= 1'b0;
            for (int i = 0; i < ROB_DEPTH; i++) begin
                done_q[i] <= 1'b0;
            end
        end else begin
            if (in_valid) begin
                done_q[tail] <= 1'b0;
                tail         <= tail + 1'b1;
            end
            if (cdb_valid) begin
                done_q[cdb_tag] <= 1'b1;
            end
            commit_valid <= fire;
            if (fire) begin
                head <= head + 1'b1;
            end
            count <= count + ROB_CNT_W'(in_valid) - ROB_CNT_W'(fire);
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            rd_q[tail] <= in_rd;
        end
        if (cdb_valid) begin
            value_q[cdb_tag] <= cdb_data;
        end
        if (fire) begin
            commit_rd   <= rd_q[head];
            commit_data <= value_q[head];
            commit_tag  <= head;
        end
    end

endmodule

// File: rtl/alu_unit.sv
`timescale 1ns/10ps

module alu_unit import ooo_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     issue_valid,
    input  alu_op_e  issue_op,
    input  data_t    issue_a,
    input  data_t    issue_b,
    input  rob_tag_t issue_tag,
    output logic     cdb_valid,
    output rob_tag_t cdb_tag,
    output data_t    cdb_data
);

    data_t result;

    always_comb begin
        case (issue_op)
            OP_ADD, OP_ADDI: result = issue_a + issue_b;
            OP_SUB:          result = issue_a - issue_b;
            OP_AND:          result = issue_a & issue_b;
            OP_OR:           result = issue_a | issue_b;
            OP_XOR:          result = issue_a ^ issue_b;
            // Signed compare, result is 1 or 0
            OP_SLT:          result = data_t'($signed(issue_a) < $signed(issue_b));
            default:         result = '0;
        endcase
    end

    // One CDB cycle per issued operation
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        cdb_tag  <= issue_tag;
        cdb_data <= result;
    end

endmodule

// File: rtl/reservation_station.sv
`timescale 1ns/10ps

module reservation_station import ooo_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            in_valid,
    input  alu_op_e         in_op,
    input  logic [IMM_W-1:0] in_imm,
    input  rob_tag_t        alloc_tag,
    input  data_t           src1_value,
    input  data_t           src2_value,
    input  logic            src1_pending,
    input  logic            src2_pending,
    input  rob_tag_t        src1_tag,
    input  rob_tag_t        src2_tag,
    input  logic            rob_done1,
    input  logic            rob_done2,
    input  data_t           rob_value1,
    input  data_t           rob_value2,
    input  logic            cdb_valid,
    input  rob_tag_t        cdb_tag,
    input  data_t           cdb_data,
    output logic            issue_valid,
    output alu_op_e         issue_op,
    output data_t           issue_a,
    output data_t           issue_b,
    output rob_tag_t        issue_tag
);

    // Slots are indexed by ROB tag, one per ROB entry
    logic     valid_q [ROB_DEPTH];
    alu_op_e  op_q    [ROB_DEPTH];
    data_t    a_q     [ROB_DEPTH];
    data_t    b_q     [ROB_DEPTH];
    logic     a_rdy   [ROB_DEPTH];
    logic     b_rdy   [ROB_DEPTH];
    rob_tag_t a_tag   [ROB_DEPTH];
    rob_tag_t b_tag   [ROB_DEPTH];

    logic [DATA_W:0] opnd1;
    logic [DATA_W:0] opnd2;
    logic            found;
    rob_tag_t        sel;
    rob_tag_t        idx;

    // Returns {ready, value} for a source at dispatch
    function automatic logic [DATA_W:0] form_operand(
        input logic     pending,
        input rob_tag_t tag,
        input data_t    reg_val,
        input logic     done,
        input data_t    rob_val,
        input logic     bus_valid,
        input rob_tag_t bus_tag,
        input data_t    bus_data
    );
        if (!pending) begin
            return {1'b1, reg_val};
        end else if (done) begin
            return {1'b1, rob_val};
        end else if (bus_valid && bus_tag == tag) begin
            return {1'b1, bus_data};
        end
        return {1'b0, {DATA_W{1'b0}}};
    endfunction

    always_comb begin
        opnd1 = form_operand(src1_pending, src1_tag, src1_value, rob_done1, rob_value1,
                             cdb_valid, cdb_tag, cdb_data);
        opnd2 = form_operand(src2_pending, src2_tag, src2_value, rob_done2, rob_value2,
                             cdb_valid, cdb_tag, cdb_data);
        if (in_op == OP_ADDI) begin
            opnd2 = {1'b1, {(DATA_W-IMM_W){in_imm[IMM_W-1]}}, in_imm};
        end
    end

    // Live entries sit between ROB head and tail, so scanning upward from
    // the tail reaches the oldest one first
    always_comb begin
        found = 1'b0;
        sel   = '0;
        idx   = '0;
        for (int i = 0; i < ROB_DEPTH; i++) begin
            idx = alloc_tag + rob_tag_t'(i);
            if (!found && valid_q[idx] && a_rdy[idx] && b_rdy[idx]) begin
                found = 1'b1;
                sel   = idx;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < ROB_DEPTH; i++) begin
                valid_q[i] <= 1'b0;
            end
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= found;
            if (found) begin
                valid_q[sel] <= 1'b0;
            end
            if (in_valid) begin
                valid_q[alloc_tag] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        // Wakeup from the CDB
        for (int i = 0; i < ROB_DEPTH; i++) begin
            if (cdb_valid && !a_rdy[i] && a_tag[i] == cdb_tag) begin
                a_q[i]   <= cdb_data;
                a_rdy[i] <= 1'b1;
            end
            if (cdb_valid && !b_rdy[i] && b_tag[i] == cdb_tag) begin
                b_q[i]   <= cdb_data;
                b_rdy[i] <= 1'b1;
            end
        end
        if (in_valid) begin
            op_q[alloc_tag]  <= in_op;
            a_q[alloc_tag]   <= opnd1[DATA_W-1:0];
            a_rdy[alloc_tag] <= opnd1[DATA_W];
            a_tag[alloc_tag] <= src1_tag;
            b_q[alloc_tag]   <= opnd2[DATA_W-1:0];
            b_rdy[alloc_tag] <= opnd2[DATA_W];
            b_tag[alloc_tag] <= src2_tag;
        end
        issue_op  <= op_q[sel];
        issue_a   <= a_q[sel];
        issue_b   <= b_q[sel];
        issue_tag <= sel;
    end

endmodule

// File: rtl/rename_regfile.sv
`timescale 1ns/10ps

module rename_regfile import ooo_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  reg_idx_t in_rd,
    input  reg_idx_t in_rs1,
    input  reg_idx_t in_rs2,
    input  rob_tag_t alloc_tag,
    input  logic     commit_valid,
    input  reg_idx_t commit_rd,
    input  data_t    commit_data,
    input  rob_tag_t commit_tag,
    output data_t    src1_value,
    output data_t    src2_value,
    output logic     src1_pending,
    output logic     src2_pending,
    output rob_tag_t src1_tag,
    output rob_tag_t src2_tag
);

    data_t    regs   [REG_COUNT];
    logic     pend   [REG_COUNT];
    rob_tag_t tag_q  [REG_COUNT];
    logic     byp1;
    logic     byp2;

    // The ROB has already freed the committing entry, so its value is
    // taken straight from the commit port until the register is written
    assign byp1 = pend[in_rs1] && commit_valid && (tag_q[in_rs1] == commit_tag);
    assign byp2 = pend[in_rs2] && commit_valid && (tag_q[in_rs2] == commit_tag);

    assign src1_value   = byp1 ? commit_data : regs[in_rs1];
    assign src2_value   = byp2 ? commit_data : regs[in_rs2];
    assign src1_pending = pend[in_rs1] && !byp1;
    assign src2_pending = pend[in_rs2] && !byp2;
    assign src1_tag     = tag_q[in_rs1];
    assign src2_tag     = tag_q[in_rs2];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i]  <= '0;
                pend[i]  <= 1'b0;
                tag_q[i] <= '0;
            end
        end else begin
            // Register 0 is never written and never renamed
            if (commit_valid && commit_rd != '0) begin
                regs[commit_rd] <= commit_data;
                // Only the newest writer may clear the pending flag
                if (tag_q[commit_rd] == commit_tag) begin
                    pend[commit_rd] <= 1'b0;
                end
            end
            // Later assignment, so a same-cycle dispatch wins
            if (in_valid && in_rd != '0) begin
                pend[in_rd]  <= 1'b1;
                tag_q[in_rd] <= alloc_tag;
            end
        end
    end

endmodule

// File: rtl/ooo_pkg.sv
package ooo_pkg;

    // Datapath and architectural sizes
    localparam int DATA_W    = 32;
    localparam int REG_COUNT = 8;
    localparam int IMM_W     = 16;

    // ROB entries, also the RS entry count and the dispatch credit count.
    // Must stay a power of two so that tag arithmetic wraps on its own
    localparam int ROB_DEPTH = 8;

    localparam int REG_IDX_W = $clog2(REG_COUNT);
    localparam int ROB_TAG_W = $clog2(ROB_DEPTH);

    // Occupancy counter needs to hold ROB_DEPTH itself
    localparam int ROB_CNT_W = ROB_TAG_W + 1;

    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // ROB entry index, doubles as the rename tag
    typedef logic [ROB_TAG_W-1:0] rob_tag_t;

    typedef logic [DATA_W-1:0] data_t;

    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_AND  = 3'd2,
        OP_OR   = 3'd3,
        OP_XOR  = 3'd4,
        OP_SLT  = 3'd5,
        // Register plus sign-extended immediate
        OP_ADDI = 3'd6
    } alu_op_e;

endpackage
